// ==== Makefile ====
# Verilator build and run for the copper testbench

VERILATOR ?= verilator
TOP       ?= copper_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0

BIN  := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	-./$(BIN) | tee $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== filelist.f ====
rtl/copper_pkg.sv
rtl/copper_sequencer.sv
rtl/copper_decode.sv
rtl/copper_position_compare.sv
rtl/copper_xr_writer.sv
rtl/copper.sv
tb/copper_tb.sv

// ==== rtl/copper.sv ====
`timescale 1ns/10ps

module copper import copper_pkg::*; (
    input  logic               clk,
    input  logic               copp_reset,
    // Host access to the control register
    input  logic               copp_reg_wr_i,
    input  logic [15:0]        copp_reg_data_i,
    // Beam position from video timing
    input  logic [POS_W-1:0]   h_count_i,
    input  logic [POS_W-1:0]   v_count_i,
    // Copper memory read port
    output logic               coppermem_rd_en_o,
    output logic [PC_W-1:0]    coppermem_rd_addr_o,
    input  logic [INSN_W-1:0]  coppermem_rd_data_i,
    // XR write port
    output logic               xr_wr_en_o,
    input  logic               xr_wr_ack_i,
    output logic [XR_AW-1:0]   xr_wr_addr_o,
    output logic [XR_DW-1:0]   xr_wr_data_o
);

    // Latched instruction and its decoded fields
    logic [INSN_W-1:0] insn;
    copper_op_e        op;
    logic              ignore_v;
    logic              ignore_h;
    logic [POS_W-1:0]  v_pos;
    logic [POS_W-1:0]  h_pos;
    logic [PC_W-1:0]   jump_pc;
    logic [XR_AW-1:0]  xr_addr;
    logic [XR_DW-1:0]  xr_data;

    // Handshake between sequencer and the helper blocks
    logic              compare_en;
    logic              position_met;
    logic              move_strobe;

    // Fetch, program counter and FSM
    copper_sequencer u_sequencer (
        .clk                 (clk),
        .copp_reset          (copp_reset),
        .copp_reg_wr_i       (copp_reg_wr_i),
        .copp_reg_data_i     (copp_reg_data_i),
        .h_count_i           (h_count_i),
        .v_count_i           (v_count_i),
        .coppermem_rd_data_i (coppermem_rd_data_i),
        .coppermem_rd_en_o   (coppermem_rd_en_o),
        .coppermem_rd_addr_o (coppermem_rd_addr_o),
        .insn_o              (insn),
        .op_i                (op),
        .jump_pc_i           (jump_pc),
        .position_met_i      (position_met),
        .compare_en_o        (compare_en),
        .move_strobe_o       (move_strobe)
    );

    // Field extraction
    copper_decode u_decode (
        .insn_i     (insn),
        .op_o       (op),
        .ignore_v_o (ignore_v),
        .ignore_h_o (ignore_h),
        .v_pos_o    (v_pos),
        .h_pos_o    (h_pos),
        .jump_pc_o  (jump_pc),
        .xr_addr_o  (xr_addr),
        .xr_data_o  (xr_data)
    );

    // WAIT and SKIP condition
    copper_position_compare u_compare (
        .clk            (clk),
        .compare_en_i   (compare_en),
        .h_count_i      (h_count_i),
        .v_count_i      (v_count_i),
        .v_pos_i        (v_pos),
        .h_pos_i        (h_pos),
        .ignore_v_i     (ignore_v),
        .ignore_h_i     (ignore_h),
        .position_met_o (position_met)
    );

    // MOVE result goes out on the XR bus
    copper_xr_writer u_xr_writer (
        .clk           (clk),
        .copp_reset    (copp_reset),
        .move_strobe_i (move_strobe),
        .xr_addr_i     (xr_addr),
        .xr_data_i     (xr_data),
        .xr_wr_ack_i   (xr_wr_ack_i),
        .xr_wr_en_o    (xr_wr_en_o),
        .xr_wr_addr_o  (xr_wr_addr_o),
        .xr_wr_data_o  (xr_wr_data_o)
    );

endmodule

// ==== rtl/copper_decode.sv ====
`timescale 1ns/10ps

module copper_decode import copper_pkg::*; (
    input  logic [INSN_W-1:0] insn_i,
    output copper_op_e        op_o,
    output logic              ignore_v_o,
    output logic              ignore_h_o,
    output logic [POS_W-1:0]  v_pos_o,
    output logic [POS_W-1:0]  h_pos_o,
    output logic [PC_W-1:0]   jump_pc_o,
    output logic [XR_AW-1:0]  xr_addr_o,
    output logic [XR_DW-1:0]  xr_data_o
);

    // Opcode sits in the top three bits
    assign op_o = copper_op_e'(insn_i[31:29]);

    // WAIT and SKIP flags in the low bits of the second half
    assign ignore_v_o = insn_i[0];
    assign ignore_h_o = insn_i[1];

    // Vertical position shares its bits with the MOVEC address
    assign v_pos_o = insn_i[26:16];
    assign h_pos_o = insn_i[14:4];

    // JMP target is word aligned in the encoding, drop bit 16
    assign jump_pc_o = insn_i[26:17];

    // Every MOVE carries its data in the low half
    assign xr_data_o = insn_i[15:0];

    // XR target address by MOVE variant
    always_comb begin
        case (op_o)
            OP_MOVER: begin
                // Plain register number
                xr_addr_o = {8'h00, insn_i[23:16]};
            end
            OP_MOVEP: begin
                // 512 entry colour window
                xr_addr_o = {XR_COLOR_BASE[15:9], insn_i[24:16]};
            end
            OP_MOVEC: begin
                // 2K copper memory window
                xr_addr_o = {XR_COPPER_BASE[15:11], insn_i[26:16]};
            end
            default: begin
                // No target for non-move or reserved codes
                xr_addr_o = '0;
            end
        endcase
    end

endmodule

// ==== rtl/copper_pkg.sv ====
package copper_pkg;

    // Program counter covers 1K instruction words
    localparam int PC_W = 10;

    // Beam counters and compare positions
    localparam int POS_W = 11;

    // One instruction is a full 32-bit word
    localparam int INSN_W = 32;

    // XR write bus
    localparam int XR_AW = 16;
    localparam int XR_DW = 16;

    // XR memory windows, only the upper bits take part in address composition
    localparam logic [XR_AW-1:0] XR_COLOR_BASE  = 16'h8000;
    localparam logic [XR_AW-1:0] XR_COPPER_BASE = 16'hC000;

    // 640x480 frame totals including blanking
    localparam int H_TOTAL = 800;
    localparam int V_TOTAL = 525;

    // Restart a few pixels before the end of the last line
    localparam int RESTART_H_OFFSET = 4;
    localparam logic [POS_W-1:0] RESTART_H = POS_W'(H_TOTAL - RESTART_H_OFFSET);
    localparam logic [POS_W-1:0] RESTART_V = POS_W'(V_TOTAL - 1);

    // Opcode in instruction bits 31:29
    typedef enum logic [2:0] {
        OP_WAIT   = 3'b000,
        OP_SKIP   = 3'b001,
        OP_JUMP   = 3'b010,
        OP_MOVER  = 3'b011,
        OP_RSVD_F = 3'b100,
        OP_MOVEP  = 3'b101,
        OP_MOVEC  = 3'b110,
        OP_RSVD   = 3'b111
    } copper_op_e;

    // Execution FSM states
    typedef enum logic [2:0] {
        ST_INIT    = 3'b000,
        ST_WAIT    = 3'b001,
        ST_LATCH   = 3'b010,
        ST_PRECOMP = 3'b011,
        ST_EXEC    = 3'b100
    } copper_state_e;

endpackage

// ==== rtl/copper_position_compare.sv ====
`timescale 1ns/10ps

module copper_position_compare import copper_pkg::*; (
    input  logic             clk,
    input  logic             compare_en_i,
    input  logic [POS_W-1:0] h_count_i,
    input  logic [POS_W-1:0] v_count_i,
    input  logic [POS_W-1:0] v_pos_i,
    input  logic [POS_W-1:0] h_pos_i,
    input  logic             ignore_v_i,
    input  logic             ignore_h_i,
    output logic             position_met_o
);

    // Per-axis result, registered on the PRECOMP cycle
    logic v_reached;
    logic h_reached;

    // Reached means the beam is at or past the target
    always_ff @(posedge clk) begin
        if (compare_en_i) begin
            v_reached <= (v_count_i >= v_pos_i);
            h_reached <= (h_count_i >= h_pos_i);
        end
    end

    // Ignored axis counts as reached
    // Both ignored gives a constant true
    assign position_met_o = (v_reached | ignore_v_i) & (h_reached | ignore_h_i);

endmodule

// ==== rtl/copper_sequencer.sv ====
`timescale 1ns/10ps

module copper_sequencer import copper_pkg::*; (
    input  logic               clk,
    input  logic               copp_reset,
    input  logic               copp_reg_wr_i,
    input  logic [15:0]        copp_reg_data_i,
    input  logic [POS_W-1:0]   h_count_i,
    input  logic [POS_W-1:0]   v_count_i,
    input  logic [INSN_W-1:0]  coppermem_rd_data_i,
    output logic               coppermem_rd_en_o,
    output logic [PC_W-1:0]    coppermem_rd_addr_o,
    output logic [INSN_W-1:0]  insn_o,
    input  copper_op_e         op_i,
    input  logic [PC_W-1:0]    jump_pc_i,
    input  logic               position_met_i,
    output logic               compare_en_o,
    output logic               move_strobe_o
);

    // Control register contents
    logic              copper_en;
    logic [PC_W-1:0]   init_pc;

    copper_state_e     state;
    logic [PC_W-1:0]   pc;
    logic              rd_strobe;
    logic [INSN_W-1:0] insn;

    logic              frame_restart;
    logic              wait_forever;
    logic              wait_met;
    logic              is_move;

    // Restart point sits just ahead of the first visible pixel
    assign frame_restart = (h_count_i == RESTART_H) && (v_count_i == RESTART_V);

    // WAIT with both axes ignored parks until the next restart
    // Flag bits come straight from the latched word
    assign wait_forever = insn[0] & insn[1];
    assign wait_met     = position_met_i & ~wait_forever;

    assign is_move = (op_i == OP_MOVER) || (op_i == OP_MOVEP) || (op_i == OP_MOVEC);

    // Comparator samples the beam during PRECOMP
    assign compare_en_o = (state == ST_PRECOMP);

    // One strobe per executed MOVE, suppressed when a restart takes over
    assign move_strobe_o = (state == ST_EXEC) && is_move && !frame_restart;

    assign coppermem_rd_en_o   = rd_strobe;
    assign coppermem_rd_addr_o = pc;
    assign insn_o              = insn;

    // Control register, written by the host
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            copper_en <= 1'b0;
            init_pc   <= '0;
        end else if (copp_reg_wr_i) begin
            copper_en <= copp_reg_data_i[15];
            init_pc   <= copp_reg_data_i[PC_W-1:0];
        end
    end

    // Instruction latch, fetched word lands two edges after the read strobe
    always_ff @(posedge clk) begin
        if (state == ST_LATCH) begin
            insn <= coppermem_rd_data_i;
        end
    end

    // Execution FSM and program counter
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            state     <= ST_INIT;
            pc        <= '0;
            rd_strobe <= 1'b0;
        end else begin
            // Read strobe is a single cycle pulse by default
            rd_strobe <= 1'b0;

            if (frame_restart) begin
                state <= ST_INIT;
                pc    <= init_pc;
            end else begin
                case (state)
                    // Idle here while disabled
                    ST_INIT: begin
                        if (copper_en) begin
                            rd_strobe <= 1'b1;
                            state     <= ST_WAIT;
                        end
                    end
                    // Memory is registering the word at pc
                    ST_WAIT: begin
                        if (copper_en) begin
                            // Step ahead now, memory already has the old address
                            pc    <= pc + 1'b1;
                            state <= ST_LATCH;
                        end else begin
                            state <= ST_INIT;
                        end
                    end
                    ST_LATCH: begin
                        state <= ST_PRECOMP;
                    end
                    // Beam comparison registered this cycle
                    ST_PRECOMP: begin
                        state <= ST_EXEC;
                    end
                    ST_EXEC: begin
                        // Next fetch starts here unless a WAIT keeps looping
                        rd_strobe <= 1'b1;
                        state     <= ST_WAIT;
                        case (op_i)
                            OP_WAIT: begin
                                if (!wait_met) begin
                                    // Retest on the next pass
                                    rd_strobe <= 1'b0;
                                    state     <= ST_PRECOMP;
                                end
                            end
                            OP_SKIP: begin
                                // Jump over the following word
                                if (position_met_i) begin
                                    pc <= pc + 1'b1;
                                end
                            end
                            OP_JUMP: begin
                                pc <= jump_pc_i;
                            end
                            // MOVEs only strobe the XR writer
                            // Reserved codes fall through as no-ops
                            default: begin
                            end
                        endcase
                    end
                    default: begin
                        state <= ST_INIT;
                    end
                endcase
            end
        end
    end

endmodule

// ==== rtl/copper_xr_writer.sv ====
`timescale 1ns/10ps

module copper_xr_writer import copper_pkg::*; (
    input  logic             clk,
    input  logic             copp_reset,
    input  logic             move_strobe_i,
    input  logic [XR_AW-1:0] xr_addr_i,
    input  logic [XR_DW-1:0] xr_data_i,
    input  logic             xr_wr_ack_i,
    output logic             xr_wr_en_o,
    output logic [XR_AW-1:0] xr_wr_addr_o,
    output logic [XR_DW-1:0] xr_wr_data_o
);

    // Write request stays up until acknowledged
    // A fresh MOVE in the ack cycle keeps it up
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            xr_wr_en_o <= 1'b0;
        end else if (move_strobe_i) begin
            xr_wr_en_o <= 1'b1;
        end else if (xr_wr_ack_i) begin
            xr_wr_en_o <= 1'b0;
        end
    end

    // Address and data, a pending write is simply overwritten
    always_ff @(posedge clk) begin
        if (move_strobe_i) begin
            xr_wr_addr_o <= xr_addr_i;
            xr_wr_data_o <= xr_data_i;
        end
    end

endmodule

// ==== tb/copper_tb.sv ====
`timescale 1ns/10ps

module copper_tb;

    // Opcode encodings and the restart position of the beam
    localparam logic [2:0]  OPC_WAIT  = 3'b000;
    localparam logic [2:0]  OPC_SKIP  = 3'b001;
    localparam logic [2:0]  OPC_JUMP  = 3'b010;
    localparam logic [2:0]  OPC_MOVER = 3'b011;
    localparam logic [2:0]  OPC_MOVEP = 3'b101;
    localparam logic [2:0]  OPC_MOVEC = 3'b110;
    localparam logic [10:0] RST_H     = 11'd796;
    localparam logic [10:0] RST_V     = 11'd524;

    logic        clk;
    logic        copp_reset;
    logic        copp_reg_wr_i;
    logic [15:0] copp_reg_data_i;
    logic [10:0] h_count_i;
    logic [10:0] v_count_i;
    logic        coppermem_rd_en_o;
    logic [9:0]  coppermem_rd_addr_o;
    logic [31:0] coppermem_rd_data_i;
    logic        xr_wr_en_o;
    logic        xr_wr_ack_i;
    logic [15:0] xr_wr_addr_o;
    logic [15:0] xr_wr_data_o;

    logic [31:0] mem [0:1023];
    logic [31:0] lfsr = 32'h0479_4118;
    logic [15:0] exp_addr [$];
    logic [15:0] exp_data [$];
    logic [10:0] held_v;
    logic [10:0] held_h;
    // Read pulse seen in the previous cycle and its address
    logic        rd_pending = 1'b0;
    logic [9:0]  rd_addr_q;
    // Where the reference model stopped and how far it ran
    logic [9:0]  model_pc;
    int          model_steps;

    copper uut (
        .clk                 (clk),
        .copp_reset          (copp_reset),
        .copp_reg_wr_i       (copp_reg_wr_i),
        .copp_reg_data_i     (copp_reg_data_i),
        .h_count_i           (h_count_i),
        .v_count_i           (v_count_i),
        .coppermem_rd_en_o   (coppermem_rd_en_o),
        .coppermem_rd_addr_o (coppermem_rd_addr_o),
        .coppermem_rd_data_i (coppermem_rd_data_i),
        .xr_wr_en_o          (xr_wr_en_o),
        .xr_wr_ack_i         (xr_wr_ack_i),
        .xr_wr_addr_o        (xr_wr_addr_o),
        .xr_wr_data_o        (xr_wr_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // Opcode on top of random payload bits
    function automatic logic [31:0] make_word(input logic [2:0] op);
        logic [31:0] r;
        r = rand_bits(29);
        return {op, r[28:0]};
    endfunction

    // Random MOVE variant or reserved code
    function automatic logic [31:0] rand_move_word();
        logic [2:0] sel;
        logic [2:0] op;
        sel = 3'(rand_bits(3));
        case (sel)
            3'd0, 3'd5: op = OPC_MOVER;
            3'd1, 3'd6: op = OPC_MOVEP;
            3'd2, 3'd7: op = OPC_MOVEC;
            3'd3:       op = 3'b100;
            default:    op = 3'b111;
        endcase
        return make_word(op);
    endfunction

    function automatic logic beam_met(input logic [31:0] w, input logic [10:0] v,
                                      input logic [10:0] h);
        return (v >= w[26:16] || w[0]) && (h >= w[14:4] || w[1]);
    endfunction

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    task automatic fail_run(input string why);
        $display("%0t ns: %s", $time, why);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    // Walks the program the way the copper should and queues its XR writes
    task automatic run_model(input logic [9:0] start, input logic [10:0] v,
                             input logic [10:0] h);
        logic [9:0]  pc;
        logic [31:0] w;
        logic        done;
        pc = start;
        done = 1'b0;
        model_steps = 0;
        while (!done && model_steps < 256) begin
            w = mem[pc];
            model_steps++;
            case (w[31:29])
                OPC_WAIT: begin
                    // Both flags set or an unmet position stops the walk
                    if (w[1:0] == 2'b11 || !beam_met(w, v, h)) begin
                        done = 1'b1;
                    end else begin
                        pc = pc + 10'd1;
                    end
                end
                OPC_SKIP: pc = pc + (beam_met(w, v, h) ? 10'd2 : 10'd1);
                OPC_JUMP: pc = w[26:17];
                OPC_MOVER, OPC_MOVEP, OPC_MOVEC: begin
                    if (w[31:29] == OPC_MOVER) exp_addr.push_back({8'h00, w[23:16]});
                    else if (w[31:29] == OPC_MOVEP) exp_addr.push_back({7'h40, w[24:16]});
                    else exp_addr.push_back({5'h18, w[26:16]});
                    exp_data.push_back(w[15:0]);
                    pc = pc + 10'd1;
                end
                default: pc = pc + 10'd1;
            endcase
        end
        model_pc = pc;
    endtask

    // Memory read port and XR acknowledge are driven just after the edge
    always @(posedge clk) begin
        #1;
        // Registered read returns the word one edge after the read pulse
        if (rd_pending) begin
            coppermem_rd_data_i = mem[rd_addr_q];
        end
        rd_pending = coppermem_rd_en_o;
        rd_addr_q  = coppermem_rd_addr_o;
        if (xr_wr_en_o && !xr_wr_ack_i) begin
            if (exp_addr.size() == 0) begin
                fail_run("XR write appeared that the program should not produce");
            end
            check(32'(xr_wr_addr_o), 32'(exp_addr.pop_front()), "XR address");
            check(32'(xr_wr_data_o), 32'(exp_data.pop_front()), "XR data");
            xr_wr_ack_i = 1'b1;
        end else begin
            xr_wr_ack_i = 1'b0;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Every word parks as a both-ignored WAIT with its address in the position bits
    task automatic clear_mem();
        for (int a = 0; a < 1024; a++) begin
            mem[a] = {6'b000000, 10'(a), 14'h0000, 2'b11};
        end
    endtask

    task automatic random_beam();
        held_v = 11'(rand_bits(9));
        held_h = 11'(rand_bits(9));
        v_count_i = held_v;
        h_count_i = held_h;
    endtask

    // Control register write and then one cycle at the restart position
    task automatic start_program(input logic [9:0] pc);
        next_cycle();
        copp_reg_wr_i = 1'b1;
        copp_reg_data_i = {1'b1, 5'b00000, pc};
        next_cycle();
        copp_reg_wr_i = 1'b0;
        v_count_i = RST_V;
        h_count_i = RST_H;
        next_cycle();
        v_count_i = held_v;
        h_count_i = held_h;
    endtask

    // Waits for the queued writes and then watches a little longer for strays
    task automatic wait_writes(input int limit);
        int n;
        n = 0;
        while (exp_addr.size() != 0) begin
            next_cycle();
            n++;
            if (n > limit) begin
                fail_run("Timeout, the copper stalled before all expected XR writes");
            end
        end
        repeat (40) next_cycle();
    endtask

    task automatic run_from(input logic [9:0] base);
        run_model(base, held_v, held_h);
        start_program(base);
        wait_writes(4 * model_steps + 200);
    endtask

    task automatic test_idle();
        for (int i = 0; i < 40; i++) begin
            next_cycle();
            v_count_i = (i == 20) ? RST_V : held_v;
            h_count_i = (i == 20) ? RST_H : held_h;
            check(32'(coppermem_rd_en_o), 32'd0, "read strobe while disabled");
            check(32'(xr_wr_en_o), 32'd0, "XR enable while disabled");
        end
    endtask

    task automatic test_moves();
        logic [9:0] base;
        int n;
        clear_mem();
        random_beam();
        base = {5'(rand_bits(5)), 5'b00000};
        n = 8 + int'(rand_bits(4));
        for (int i = 0; i < n; i++) begin
            mem[base + 10'(i)] = rand_move_word();
        end
        run_from(base);
    endtask

    task automatic test_skip();
        logic [9:0] base;
        clear_mem();
        random_beam();
        base = {5'(rand_bits(5)), 5'b00000};
        for (int i = 0; i < 20; i++) begin
            if (rand_bits(2) == 0) mem[base + 10'(i)] = make_word(OPC_SKIP);
            else mem[base + 10'(i)] = make_word(OPC_MOVER);
        end
        run_from(base);
    endtask

    task automatic test_wait();
        logic [9:0]  base;
        logic [10:0] vpos;
        clear_mem();
        random_beam();
        base = {5'(rand_bits(5)), 5'b00000};
        vpos = held_v + 11'd5 + 11'(rand_bits(4));
        mem[base] = make_word(OPC_MOVER);
        // Horizontal ignored and vertical target below the held beam
        mem[base + 10'd1] = {OPC_WAIT, 2'b00, vpos, 1'b0, held_h, 2'b00, 2'b10};
        mem[base + 10'd2] = make_word(OPC_MOVER);
        run_from(base);
        held_v = vpos;
        v_count_i = held_v;
        run_model(model_pc, held_v, held_h);
        wait_writes(4 * model_steps + 200);
    endtask

    task automatic test_jump_restart();
        logic [9:0] base;
        logic [9:0] target;
        clear_mem();
        random_beam();
        base = {1'b0, 4'(rand_bits(4)), 5'b00000};
        target = {1'b1, 4'(rand_bits(4)), 5'b00000};
        mem[base] = make_word(OPC_MOVER);
        mem[base + 10'd1] = {OPC_JUMP, 2'b00, target, 17'h00000};
        mem[base + 10'd2] = make_word(OPC_MOVEP);
        for (int i = 0; i < 4; i++) begin
            mem[target + 10'(i)] = rand_move_word();
        end
        run_from(base);
        // New initial PC and program are picked up at the next restart
        clear_mem();
        base = {5'(rand_bits(5)), 5'b00000};
        for (int i = 0; i < 4; i++) begin
            mem[base + 10'(i)] = make_word(OPC_MOVEC);
        end
        run_from(base);
    endtask

    initial begin
        copp_reset = 1'b1;
        copp_reg_wr_i = 1'b0;
        copp_reg_data_i = '0;
        held_v = 11'd100;
        held_h = 11'd100;
        v_count_i = held_v;
        h_count_i = held_h;
        coppermem_rd_data_i = '0;
        xr_wr_ack_i = 1'b0;
        clear_mem();
        repeat (16) @(posedge clk);
        #1;
        copp_reset = 1'b0;
        test_idle();
        repeat (3) test_moves();
        repeat (4) test_skip();
        repeat (2) test_wait();
        repeat (2) test_jump_restart();
        $display("*** PASSED ***");
        $finish;
    end

endmodule
